// File: source/soc_bus_settings.svh
`ifndef SOC_BUS_SETTINGS_SVH
`define SOC_BUS_SETTINGS_SVH

// ==========================================================================
// Address map, decoded on address bits 31 to 28
// ==========================================================================

// Block RAM
`define REGION_RAM 4'h1

// Timer peripheral
`define REGION_TIMER 4'ha

// ==========================================================================
// Slave sizes and reset values
// ==========================================================================

// RAM depth in words, indexed by address bits 10 to 2
`define RAM_WORDS 512

`define TIMER_COMPARE_RESET 32'hffff_ffff

`endif

// File: source/bus_pkg.sv
package bus_pkg;

	// ======================================================================
	// Shared bus payloads
	// ======================================================================

	// One bus data word
	typedef logic [31:0] bus_word_t;

	// Byte address, word aligned on this bus
	typedef logic [31:0] bus_addr_t;

	// Targets reachable through the decoder
	typedef enum logic [1:0]
	{
		RAM,
		TIMER,
		NONE
	} region_t;

endpackage

// File: source/periph_pkg.sv
package periph_pkg;

	// Timer register index, address bits 3 to 2
	typedef enum logic [1:0]
	{
		CONTROL = 2'd0,
		COMPARE = 2'd1,
		COUNT = 2'd2,
		STATUS = 2'd3
	} timer_reg_t;

	// Timer control word
	typedef struct packed
	{
		logic [30:0] reserved;
		logic enable;
	} timer_ctrl_t;

endpackage

// File: source/bus_access.sv
`timescale 1ns/1ns

module bus_access
(
	input logic clock,
	input logic i_rst_n,

	// Instruction port, read only
	input logic i_ia_request,
	input bus_pkg::bus_addr_t i_ia_address,
	output logic o_ia_ready,
	output bus_pkg::bus_word_t o_ia_rdata,

	// Data port
	input logic i_da_request,
	input logic i_da_rw,
	input bus_pkg::bus_addr_t i_da_address,
	input bus_pkg::bus_word_t i_da_wdata,
	output logic o_da_ready,
	output bus_pkg::bus_word_t o_da_rdata,

	// Shared bus
	output logic o_bus_request,
	output logic o_bus_rw,
	output bus_pkg::bus_addr_t o_bus_address,
	output bus_pkg::bus_word_t o_bus_wdata,
	input logic i_bus_ready,
	input bus_pkg::bus_word_t i_bus_rdata
);

	typedef enum logic [1:0]
	{
		GRANT_IDLE,
		GRANT_IA,
		GRANT_DA
	} grant_t;

	grant_t grant;
	logic ia_done;
	logic da_done;
	logic ia_pending;
	logic da_pending;

	// A port that saw ready last cycle is still letting go of its request
	assign ia_pending = i_ia_request && !ia_done;
	assign da_pending = i_da_request && !da_done;

	// ======================================================================
	// Grant state, data port has priority
	// ======================================================================

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			grant <= GRANT_IDLE;
			ia_done <= 1'b0;
			da_done <= 1'b0;
		end
		else
		begin
			ia_done <= o_ia_ready;
			da_done <= o_da_ready;
			case (grant)
				GRANT_IDLE:
				begin
					if (da_pending)
						grant <= GRANT_DA;
					else if (ia_pending)
						grant <= GRANT_IA;
				end
				default:
				begin
					// Release on the slave's answer
					if (i_bus_ready)
						grant <= GRANT_IDLE;
				end
			endcase
		end
	end

	// ======================================================================
	// Bus multiplexing and return steering
	// ======================================================================

	assign o_bus_request = (grant != GRANT_IDLE);
	assign o_bus_rw = (grant == GRANT_DA) && i_da_rw;
	assign o_bus_address = (grant == GRANT_DA) ? i_da_address : i_ia_address;
	assign o_bus_wdata = (grant == GRANT_DA) ? i_da_wdata : '0;

	assign o_ia_ready = (grant == GRANT_IA) && i_bus_ready;
	assign o_ia_rdata = (grant == GRANT_IA) ? i_bus_rdata : '0;
	assign o_da_ready = (grant == GRANT_DA) && i_bus_ready;
	assign o_da_rdata = (grant == GRANT_DA) ? i_bus_rdata : '0;

endmodule

// File: source/bus_decode.sv
`timescale 1ns/1ns

`include "soc_bus_settings.svh"

module bus_decode
(
	input logic clock,
	input logic i_rst_n,

	// From the arbiter
	input logic i_bus_request,
	input bus_pkg::bus_addr_t i_bus_address,
	output logic o_bus_ready,
	output bus_pkg::bus_word_t o_bus_rdata,

	// RAM slave
	output logic o_ram_request,
	input logic i_ram_ready,
	input bus_pkg::bus_word_t i_ram_rdata,

	// Timer slave
	output logic o_timer_request,
	input logic i_timer_ready,
	input bus_pkg::bus_word_t i_timer_rdata
);

	bus_pkg::region_t region;
	logic none_ready;

	// Region from the top nibble
	always_comb
	begin
		case (i_bus_address[31:28])
			`REGION_RAM: region = bus_pkg::RAM;
			`REGION_TIMER: region = bus_pkg::TIMER;
			default: region = bus_pkg::NONE;
		endcase
	end

	assign o_ram_request = i_bus_request && (region == bus_pkg::RAM);
	assign o_timer_request = i_bus_request && (region == bus_pkg::TIMER);

	// Unmapped responder, keeps the bus from hanging
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			none_ready <= 1'b0;
		else
			none_ready <= i_bus_request && (region == bus_pkg::NONE) && !none_ready;
	end

	// Answer of the selected slave
	always_comb
	begin
		case (region)
			bus_pkg::RAM:
			begin
				o_bus_ready = i_ram_ready;
				o_bus_rdata = i_ram_rdata;
			end
			bus_pkg::TIMER:
			begin
				o_bus_ready = i_timer_ready;
				o_bus_rdata = i_timer_rdata;
			end
			default:
			begin
				o_bus_ready = none_ready;
				o_bus_rdata = '0;
			end
		endcase
	end

endmodule

// File: source/bram.sv
`timescale 1ns/1ns

module bram
#(
	parameter int DEPTH = 512
)
(
	input logic clock,
	input logic i_request,
	input logic i_rw,
	input bus_pkg::bus_addr_t i_address,
	input bus_pkg::bus_word_t i_wdata,
	output bus_pkg::bus_word_t o_rdata,
	output logic o_ready
);

	localparam int INDEX_BITS = $clog2(DEPTH);

	bus_pkg::bus_word_t mem [DEPTH];
	logic [INDEX_BITS-1:0] index;
	logic access;

	// Word index, byte offset dropped
	assign index = i_address[INDEX_BITS+1:2];

	// One access per request, the ready cycle is not an access
	assign access = i_request && !o_ready;

	always_ff @(posedge clock)
	begin
		o_ready <= access;
		if (access)
		begin
			if (i_rw)
				mem[index] <= i_wdata;
			else
				o_rdata <= mem[index];
		end
	end

endmodule

// File: source/timer_regs.sv
`timescale 1ns/1ns

`include "soc_bus_settings.svh"

module timer_regs
(
	input logic clock,
	input logic i_rst_n,

	// Bus side
	input logic i_request,
	input logic i_rw,
	input bus_pkg::bus_addr_t i_address,
	input bus_pkg::bus_word_t i_wdata,
	output bus_pkg::bus_word_t o_rdata,
	output logic o_ready,

	// Counter side
	output logic o_enable,
	output bus_pkg::bus_word_t o_compare,
	input bus_pkg::bus_word_t i_count,
	input logic i_match,

	output logic o_interrupt
);

	periph_pkg::timer_reg_t reg_index;
	periph_pkg::timer_ctrl_t control;
	bus_pkg::bus_word_t compare;
	logic pending;
	logic access;
	logic write;

	assign reg_index = periph_pkg::timer_reg_t'(i_address[3:2]);
	assign access = i_request && !o_ready;
	assign write = access && i_rw;

	// ======================================================================
	// Control, compare and pending registers
	// ======================================================================

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_ready <= 1'b0;
			control <= '0;
			compare <= `TIMER_COMPARE_RESET;
			pending <= 1'b0;
		end
		else
		begin
			o_ready <= access;
			if (write && (reg_index == periph_pkg::CONTROL))
				control.enable <= i_wdata[0];
			if (write && (reg_index == periph_pkg::COMPARE))
				compare <= i_wdata;
			// A new match wins over a clear in the same cycle
			if (i_match)
				pending <= 1'b1;
			else if (write && (reg_index == periph_pkg::STATUS) && i_wdata[0])
				pending <= 1'b0;
		end
	end

	// Read back
	always_ff @(posedge clock)
	begin
		if (access && !i_rw)
		begin
			case (reg_index)
				periph_pkg::CONTROL: o_rdata <= bus_pkg::bus_word_t'(control);
				periph_pkg::COMPARE: o_rdata <= compare;
				periph_pkg::COUNT: o_rdata <= i_count;
				default: o_rdata <= {31'b0, pending};
			endcase
		end
	end

	assign o_enable = control.enable;
	assign o_compare = compare;
	assign o_interrupt = pending;

endmodule

// File: source/timer_counter.sv
`timescale 1ns/1ns

module timer_counter
(
	input logic clock,
	input logic i_rst_n,
	input logic i_enable,
	input bus_pkg::bus_word_t i_compare,
	output bus_pkg::bus_word_t o_count,
	output logic o_match
);

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_count <= '0;
			o_match <= 1'b0;
		end
		else
		begin
			o_match <= 1'b0;
			if (i_enable)
			begin
				// Wrap on compare and flag it for one cycle
				if (o_count == i_compare)
				begin
					o_count <= '0;
					o_match <= 1'b1;
				end
				else
					o_count <= o_count + 1'b1;
			end
		end
	end

endmodule

// File: source/soc_bus_top.sv
`timescale 1ns/1ns

`include "soc_bus_settings.svh"

module soc_bus_top
(
	input logic clock,
	input logic i_rst_n,

	// Instruction port
	input logic i_ia_request,
	input bus_pkg::bus_addr_t i_ia_address,
	output logic o_ia_ready,
	output bus_pkg::bus_word_t o_ia_rdata,

	// Data port
	input logic i_da_request,
	input logic i_da_rw,
	input bus_pkg::bus_addr_t i_da_address,
	input bus_pkg::bus_word_t i_da_wdata,
	output logic o_da_ready,
	output bus_pkg::bus_word_t o_da_rdata,

	output logic o_timer_interrupt
);

	// ======================================================================
	// Shared bus
	// ======================================================================

	logic bus_request;
	logic bus_rw;
	bus_pkg::bus_addr_t bus_address;
	bus_pkg::bus_word_t bus_wdata;
	logic bus_ready;
	bus_pkg::bus_word_t bus_rdata;

	bus_access bus_access_i
	(
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_ia_request(i_ia_request),
		.i_ia_address(i_ia_address),
		.o_ia_ready(o_ia_ready),
		.o_ia_rdata(o_ia_rdata),
		.i_da_request(i_da_request),
		.i_da_rw(i_da_rw),
		.i_da_address(i_da_address),
		.i_da_wdata(i_da_wdata),
		.o_da_ready(o_da_ready),
		.o_da_rdata(o_da_rdata),
		.o_bus_request(bus_request),
		.o_bus_rw(bus_rw),
		.o_bus_address(bus_address),
		.o_bus_wdata(bus_wdata),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata)
	);

	logic ram_request;
	logic ram_ready;
	bus_pkg::bus_word_t ram_rdata;
	logic timer_request;
	logic timer_ready;
	bus_pkg::bus_word_t timer_rdata;

	bus_decode bus_decode_i
	(
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_bus_request(bus_request),
		.i_bus_address(bus_address),
		.o_bus_ready(bus_ready),
		.o_bus_rdata(bus_rdata),
		.o_ram_request(ram_request),
		.i_ram_ready(ram_ready),
		.i_ram_rdata(ram_rdata),
		.o_timer_request(timer_request),
		.i_timer_ready(timer_ready),
		.i_timer_rdata(timer_rdata)
	);

	// ======================================================================
	// Slaves
	// ======================================================================

	bram
	#(
		.DEPTH(`RAM_WORDS)
	)
	bram_i
	(
		.clock(clock),
		.i_request(ram_request),
		.i_rw(bus_rw),
		.i_address(bus_address),
		.i_wdata(bus_wdata),
		.o_rdata(ram_rdata),
		.o_ready(ram_ready)
	);

	logic timer_enable;
	bus_pkg::bus_word_t timer_compare;
	bus_pkg::bus_word_t timer_count;
	logic timer_match;

	timer_regs timer_regs_i
	(
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_request(timer_request),
		.i_rw(bus_rw),
		.i_address(bus_address),
		.i_wdata(bus_wdata),
		.o_rdata(timer_rdata),
		.o_ready(timer_ready),
		.o_enable(timer_enable),
		.o_compare(timer_compare),
		.i_count(timer_count),
		.i_match(timer_match),
		.o_interrupt(o_timer_interrupt)
	);

	timer_counter timer_counter_i
	(
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_enable(timer_enable),
		.i_compare(timer_compare),
		.o_count(timer_count),
		.o_match(timer_match)
	);

endmodule

// File: tb/soc_bus_assertions.sv
`timescale 1ns/1ns

module soc_bus_assertions
#(
	// Arbiter view with two ports, otherwise a slave with an interrupt
	parameter bit TWO_PORTS = 1'b1
)
(
	input logic clock,
	input logic i_rst_n,
	input logic i_first_request,
	input logic i_first_ready,
	input logic i_second_request,
	input logic i_second_ready,
	input logic i_source_ready,
	input logic i_event,
	input logic i_flag
);

	int failures = 0;

	// Ready only while its request is held
	first_ready_held: assert property (@(posedge clock) disable iff (!i_rst_n)
		i_first_ready |-> i_first_request)
	else
	begin
		$error("First port ready without request");
		failures++;
	end

	if (TWO_PORTS)
	begin : g_ports
		second_ready_held: assert property (@(posedge clock) disable iff (!i_rst_n)
			i_second_ready |-> i_second_request)
		else
		begin
			$error("Second port ready without request");
			failures++;
		end

		// Each slave answer goes to exactly one port
		single_grant: assert property (@(posedge clock) disable iff (!i_rst_n)
			i_source_ready |-> (i_first_ready ^ i_second_ready))
		else
		begin
			$error("Slave answer not steered to exactly one port");
			failures++;
		end
	end
	else
	begin : g_irq
		logic event_seen;

		always_ff @(posedge clock or negedge i_rst_n)
		begin
			if (!i_rst_n)
				event_seen <= 1'b0;
			else if (i_event)
				event_seen <= 1'b1;
		end

		// Interrupt quiet before the first match
		flag_after_event: assert property (@(posedge clock) disable iff (!i_rst_n)
			!event_seen |-> !i_flag)
		else
		begin
			$error("Interrupt raised before any match");
			failures++;
		end
	end

endmodule

// File: tb/soc_bus_tb.sv
`timescale 1ns/1ns

`include "soc_bus_settings.svh"

module soc_bus_tb;

	localparam int READY_TIMEOUT = 50;
	localparam int IRQ_TIMEOUT = 200;
	localparam int TABLE_SIZE = 6;

	// Timer register map
	localparam bus_pkg::bus_addr_t TIMER_CONTROL = {`REGION_TIMER, 28'h000_0000};
	localparam bus_pkg::bus_addr_t TIMER_COMPARE = {`REGION_TIMER, 28'h000_0004};
	localparam bus_pkg::bus_addr_t TIMER_STATUS = {`REGION_TIMER, 28'h000_000c};
	localparam bus_pkg::bus_addr_t UNMAPPED = 32'h5000_0010;

	logic clock;
	logic i_rst_n;
	logic i_ia_request;
	bus_pkg::bus_addr_t i_ia_address;
	logic o_ia_ready;
	bus_pkg::bus_word_t o_ia_rdata;
	logic i_da_request;
	logic i_da_rw;
	bus_pkg::bus_addr_t i_da_address;
	bus_pkg::bus_word_t i_da_wdata;
	logic o_da_ready;
	bus_pkg::bus_word_t o_da_rdata;
	logic o_timer_interrupt;

	int seed;
	int waited;
	bus_pkg::bus_word_t rdata;
	bus_pkg::bus_word_t ia_data;
	time da_at;
	time ia_at;

	// RAM table, first and last word included
	bus_pkg::bus_addr_t table_address [TABLE_SIZE] = '{
		{`REGION_RAM, 28'h000_0000}, {`REGION_RAM, 28'h000_0004}, {`REGION_RAM, 28'h000_0120},
		{`REGION_RAM, 28'h000_0400}, {`REGION_RAM, 28'h000_07f8}, {`REGION_RAM, 28'h000_07fc}};
	bus_pkg::bus_word_t table_wdata [TABLE_SIZE];
	bus_pkg::bus_word_t table_expected [TABLE_SIZE];

	soc_bus_top dut_i
	(
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_ia_request(i_ia_request),
		.i_ia_address(i_ia_address),
		.o_ia_ready(o_ia_ready),
		.o_ia_rdata(o_ia_rdata),
		.i_da_request(i_da_request),
		.i_da_rw(i_da_rw),
		.i_da_address(i_da_address),
		.i_da_wdata(i_da_wdata),
		.o_da_ready(o_da_ready),
		.o_da_rdata(o_da_rdata),
		.o_timer_interrupt(o_timer_interrupt)
	);

	bind bus_access soc_bus_assertions #(.TWO_PORTS(1'b1)) access_checks_i
	(
		.clock(clock), .i_rst_n(i_rst_n),
		.i_first_request(i_ia_request), .i_first_ready(o_ia_ready),
		.i_second_request(i_da_request), .i_second_ready(o_da_ready),
		.i_source_ready(i_bus_ready),
		.i_event(1'b0), .i_flag(1'b0)
	);

	bind timer_regs soc_bus_assertions #(.TWO_PORTS(1'b0)) timer_checks_i
	(
		.clock(clock), .i_rst_n(i_rst_n),
		.i_first_request(i_request), .i_first_ready(o_ready),
		.i_second_request(1'b0), .i_second_ready(1'b0),
		.i_source_ready(1'b0),
		.i_event(i_match), .i_flag(o_interrupt)
	);

	always #20 clock = ~clock;

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("ERRORS FOUND");
		$fatal(1, "Timeout on %s", what);
	endtask

	// Failures counted by the bound checkers
	function automatic bit assertions_failed();
		return (dut_i.bus_access_i.access_checks_i.failures != 0)
			|| (dut_i.timer_regs_i.timer_checks_i.failures != 0);
	endfunction

	task automatic report_assertion_failure();
		$display("A bus assertion failed");
		$display("ERRORS FOUND");
		$fatal(1, "Assertion failure");
	endtask

	always @(negedge clock)
	begin
		if (assertions_failed())
			report_assertion_failure();
	end

	// ======================================================================
	// Port transfers, request dropped in the cycle after ready
	// ======================================================================

	task automatic da_transfer(input logic rw, input bus_pkg::bus_addr_t address,
		input bus_pkg::bus_word_t wdata, output bus_pkg::bus_word_t data, output time done_at);
		int cycles;
		cycles = 0;
		@(negedge clock);
		i_da_request = 1'b1;
		i_da_rw = rw;
		i_da_address = address;
		i_da_wdata = wdata;
		do
		begin
			@(negedge clock);
			cycles++;
			if (cycles > READY_TIMEOUT)
				report_timeout("data port ready");
		end
		while (!o_da_ready);
		data = o_da_rdata;
		done_at = $time;
		@(negedge clock);
		i_da_request = 1'b0;
		i_da_rw = 1'b0;
	endtask

	task automatic da_read(input bus_pkg::bus_addr_t address, output bus_pkg::bus_word_t data,
		output time done_at);
		da_transfer(1'b0, address, '0, data, done_at);
	endtask

	task automatic da_write(input bus_pkg::bus_addr_t address, input bus_pkg::bus_word_t wdata);
		bus_pkg::bus_word_t unused_data;
		time unused_at;
		da_transfer(1'b1, address, wdata, unused_data, unused_at);
	endtask

	task automatic ia_read(input bus_pkg::bus_addr_t address, output bus_pkg::bus_word_t data,
		output time done_at);
		int cycles;
		cycles = 0;
		@(negedge clock);
		i_ia_request = 1'b1;
		i_ia_address = address;
		do
		begin
			@(negedge clock);
			cycles++;
			if (cycles > READY_TIMEOUT)
				report_timeout("instruction port ready");
		end
		while (!o_ia_ready);
		data = o_ia_rdata;
		done_at = $time;
		@(negedge clock);
		i_ia_request = 1'b0;
	endtask

	initial
	begin
		seed = 32'hd0580167;
		clock = 1'b0;
		i_rst_n = 1'b0;
		i_ia_request = 1'b0;
		i_ia_address = '0;
		i_da_request = 1'b0;
		i_da_rw = 1'b0;
		i_da_address = '0;
		i_da_wdata = '0;
		repeat (8) @(posedge clock);
		@(negedge clock);
		i_rst_n = 1'b1;

		// State after reset
		check("o_ia_ready", o_ia_ready, 32'h0);
		check("o_da_ready", o_da_ready, 32'h0);
		check("o_timer_interrupt", o_timer_interrupt, 32'h0);
		da_read(TIMER_COMPARE, rdata, da_at);
		check("timer COMPARE", rdata, `TIMER_COMPARE_RESET);

		// RAM written word comes back on either port
		for (int i = 0; i < TABLE_SIZE; i++)
		begin
			table_wdata[i] = $random(seed);
			table_expected[i] = table_wdata[i];
		end
		for (int i = 0; i < TABLE_SIZE; i++)
			da_write(table_address[i], table_wdata[i]);
		for (int i = 0; i < TABLE_SIZE; i++)
		begin
			da_read(table_address[i], rdata, da_at);
			check("o_da_rdata", rdata, table_expected[i]);
		end
		for (int i = 0; i < TABLE_SIZE; i++)
		begin
			ia_read(table_address[i], rdata, ia_at);
			check("o_ia_rdata", rdata, table_expected[i]);
		end

		// Both ports on the same edge, data port first
		fork
			da_read(table_address[1], rdata, da_at);
			ia_read(table_address[4], ia_data, ia_at);
		join
		check("o_da_rdata", rdata, table_expected[1]);
		check("o_ia_rdata", ia_data, table_expected[4]);
		check("data port ready first", da_at < ia_at, 32'h1);

		// Unmapped region
		da_read(UNMAPPED, rdata, da_at);
		check("o_da_rdata unmapped", rdata, 32'h0);
		da_write(UNMAPPED, 32'h1234_5678);

		// Timer interrupt
		da_write(TIMER_COMPARE, 32'd5);
		da_write(TIMER_CONTROL, 32'd1);
		waited = 0;
		while (!o_timer_interrupt)
		begin
			@(negedge clock);
			waited++;
			if (waited > IRQ_TIMEOUT)
				report_timeout("timer interrupt");
		end
		da_read(TIMER_STATUS, rdata, da_at);
		check("timer STATUS", rdata, 32'h1);
		// Stop the counter so no later match sets pending again
		da_write(TIMER_CONTROL, 32'd0);
		da_write(TIMER_STATUS, 32'd1);
		check("o_timer_interrupt", o_timer_interrupt, 32'h0);
		da_read(TIMER_STATUS, rdata, da_at);
		check("timer STATUS", rdata, 32'h0);

		if (assertions_failed())
			report_assertion_failure();
		else
		begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

// File: soc_bus_top.f
+incdir+source
source/bus_pkg.sv
source/periph_pkg.sv
source/bus_access.sv
source/bus_decode.sv
source/bram.sv
source/timer_regs.sv
source/timer_counter.sv
source/soc_bus_top.sv
tb/soc_bus_assertions.sv
tb/soc_bus_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator and run, pass means the pass line was printed

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module soc_bus_tb -f soc_bus_top.f \
	-Mdir obj_dir -o soc_bus_sim \
	&& ./obj_dir/soc_bus_sim | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed"; exit 1; }
